// File: rtl/u712Pkg.sv
//////////////////////////////////////////////////////////////////////
// Bus structs for the CPU address phase, byte lanes and chip RAM pins
// CPU size codes and cycle timing constants
//////////////////////////////////////////////////////////////////////
`default_nettype none

package u712Pkg;

    // CPU address phase, held by the 68040 from tsN until the last ta
    typedef struct packed {
        logic [20:0] addr;
        logic [1:0]  siz;
        logic        rnW;
        logic [1:0]  tt;
    } cpuReqT;

    // Active low byte enables, uu is lane 0 at address 00
    typedef struct packed {
        logic uu;
        logic um;
        logic lm;
        logic ll;
    } laneEnT;

    // Chip RAM pins, 17 bits
    typedef struct packed {
        logic        rasN;
        logic        casN;
        logic        weN;
        logic        clke;
        logic        bank0;
        logic        bank1;
        logic [10:0] cma;
    } ramCtlT;

    // 68040 SIZ encodings
    localparam logic [1:0] SIZ_LONG = 2'b00;
    localparam logic [1:0] SIZ_BYTE = 2'b01;
    localparam logic [1:0] SIZ_WORD = 2'b10;
    localparam logic [1:0] SIZ_LINE = 2'b11;

    // Chip RAM timing in CLK40 cycles
    localparam int RAS_TO_CAS  = 2;
    localparam int CAS_TO_TA   = 1;
    localparam int BURST_BEATS = 4;

    // C1/C3 quadrants per register cycle
    localparam int REG_PHASES = 4;

    // Counter widths and terminal counts
    localparam int QUAD_CNT_W = $clog2(REG_PHASES);
    localparam int BEAT_CNT_W = $clog2(BURST_BEATS);
    localparam int WAIT_CNT_W = 2;

    localparam logic [QUAD_CNT_W-1:0] QUAD_LAST     = QUAD_CNT_W'(REG_PHASES - 1);
    localparam logic [BEAT_CNT_W-1:0] BEAT_LAST     = BEAT_CNT_W'(BURST_BEATS - 1);
    localparam logic [WAIT_CNT_W-1:0] RAS_WAIT_LAST = WAIT_CNT_W'(RAS_TO_CAS - 1);
    localparam logic [WAIT_CNT_W-1:0] CAS_WAIT_LAST = WAIT_CNT_W'(CAS_TO_TA - 1);

endpackage

`default_nettype wire

// File: rtl/byteEnable.sv
//////////////////////////////////////////////////////////////////////
// CPU and chip RAM byte lane enables from SIZ and A1:A0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module byteEnable (
    input  wire             [1:0] siz,
    input  wire             [1:0] addrLow,
    input  wire                   dmaCycle,
    input  wire                   casLN,
    input  wire                   casUN,
    output u712Pkg::laneEnT       cpuLanes,
    output u712Pkg::laneEnT       chipLanes
);
    import u712Pkg::*;

    laneEnT sizLanes;

    // Lane decode for a CPU access, all lanes off to start
    always_comb begin
        sizLanes = '1;
        case (siz)
            SIZ_LONG, SIZ_LINE: begin
                sizLanes = '0;
            end
            SIZ_WORD: begin
                // Upper or lower half of the longword
                if (!addrLow[1]) begin
                    sizLanes.uu = 1'b0;
                    sizLanes.um = 1'b0;
                end else begin
                    sizLanes.lm = 1'b0;
                    sizLanes.ll = 1'b0;
                end
            end
            SIZ_BYTE: begin
                case (addrLow)
                    2'b00:   sizLanes.uu = 1'b0;
                    2'b01:   sizLanes.um = 1'b0;
                    2'b10:   sizLanes.lm = 1'b0;
                    default: sizLanes.ll = 1'b0;
                endcase
            end
        endcase
    end

    // Agnus owns chip RAM, lanes come from its CAS strobes
    always_comb begin
        if (dmaCycle) begin
            cpuLanes  = '1;
            chipLanes = '{uu: casUN, um: casUN, lm: casLN, ll: casLN};
        end else begin
            cpuLanes  = sizLanes;
            chipLanes = sizLanes;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regCycle.sv
//////////////////////////////////////////////////////////////////////
// 68000 chip register cycle against the C1/C3 quadrants
// Strobes, regTa and the data buffer enables
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module regCycle (
    input  wire        CLK40,
    input  wire        rstN,
    input  wire        c1,
    input  wire        c3,
    input  wire        tsN,
    input  wire        regSpaceN,
    input  wire        rnW,
    input  wire  [1:0] siz,
    input  wire  [1:0] addrLow,
    input  wire        dmaCycle,
    output logic       asN,
    output logic       udsN,
    output logic       ldsN,
    output logic       regEnN,
    output logic       regTa,
    output logic       dbDir,
    output logic       vBufEnN,
    output logic       drdEnN,
    output logic       drdDir
);
    import u712Pkg::*;

    typedef enum logic [1:0] {
        REG_IDLE,
        REG_WAIT,
        REG_STROBE,
        REG_ACK
    } regStateT;

    regStateT              state;
    logic [2:0]            c1Sh;
    logic [2:0]            c3Sh;
    logic                  c1Rise;
    logic                  quadEdge;
    logic [QUAD_CNT_W-1:0] quadCnt;
    logic                  udsSel;
    logic                  ldsSel;
    logic                  regBusy;

    //////////////////////////////////////////////////////////////////////
    // Phase clock sync
    //////////////////////////////////////////////////////////////////////

    // Two flop sync, bit 2 holds the previous sample
    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            c1Sh <= '0;
            c3Sh <= '0;
        end else begin
            c1Sh <= {c1Sh[1:0], c1};
            c3Sh <= {c3Sh[1:0], c3};
        end
    end

    assign c1Rise = c1Sh[1] & ~c1Sh[2];
    // Any C1 or C3 transition starts a new quadrant
    assign quadEdge = (c1Sh[1] ^ c1Sh[2]) | (c3Sh[1] ^ c3Sh[2]);

    // Byte at even address on UDS, odd on LDS, wider sizes use both
    always_comb begin
        udsSel = 1'b1;
        ldsSel = 1'b1;
        if (siz == SIZ_BYTE) begin
            case (addrLow)
                2'b00, 2'b10: ldsSel = 1'b0;
                default:      udsSel = 1'b0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register cycle FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            state   <= REG_IDLE;
            quadCnt <= '0;
            asN     <= 1'b1;
            udsN    <= 1'b1;
            ldsN    <= 1'b1;
            regTa   <= 1'b0;
        end else begin
            regTa <= 1'b0;
            case (state)
                REG_IDLE: begin
                    if (!tsN && !regSpaceN) begin
                        state <= REG_WAIT;
                    end
                end
                REG_WAIT: begin
                    // AS goes out on a C1 rising quadrant
                    if (c1Rise) begin
                        asN     <= 1'b0;
                        quadCnt <= '0;
                        state   <= REG_STROBE;
                        if (!rnW) begin
                            udsN <= ~udsSel;
                            ldsN <= ~ldsSel;
                        end
                    end
                end
                REG_STROBE: begin
                    if (quadEdge) begin
                        quadCnt <= quadCnt + 1'b1;
                        if (quadCnt == QUAD_LAST) begin
                            asN   <= 1'b1;
                            udsN  <= 1'b1;
                            ldsN  <= 1'b1;
                            regTa <= 1'b1;
                            state <= REG_ACK;
                        end else if (rnW && quadCnt == '0) begin
                            // Read strobes trail AS by a quadrant
                            udsN <= ~udsSel;
                            ldsN <= ~ldsSel;
                        end
                    end
                end
                default: begin
                    // Hold through the ta cycle, then back to idle
                    if (!regTa) begin
                        state <= REG_IDLE;
                    end
                end
            endcase
        end
    end

    // Buffer control
    assign regBusy = (state != REG_IDLE);
    assign regEnN  = asN;
    assign dbDir   = regBusy & rnW;
    assign vBufEnN = ~regBusy;
    // RAM buffers off while Agnus or a register cycle has the bus
    assign drdEnN  = dmaCycle | regBusy;
    assign drdDir  = rnW;

endmodule

`default_nettype wire

// File: rtl/chipRamCycle.sv
//////////////////////////////////////////////////////////////////////
// Chip RAM sequencer with RAS/CAS/WE, row and column mux, bank select
// Four beat line bursts and the DMA ownership flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module chipRamCycle (
    input  wire                    CLK40,
    input  wire                    rstN,
    input  wire                    tsN,
    input  wire                    ramSpaceN,
    input  wire u712Pkg::cpuReqT   cpu,
    input  wire                    agnusDmaN,
    output u712Pkg::ramCtlT        ram,
    output logic                   ramTa,
    output logic                   burstCycle,
    output logic                   dmaCycle,
    output logic                   dbEnN
);
    import u712Pkg::*;

    typedef enum logic [2:0] {
        RAM_IDLE,
        RAM_RAS_WAIT,
        RAM_CAS_WAIT,
        RAM_BEAT,
        RAM_PRE
    } ramStateT;

    ramStateT              state;
    logic                  cpuStart;
    logic [10:0]           colQ;
    logic [WAIT_CNT_W-1:0] waitCnt;
    logic [BEAT_CNT_W-1:0] beatCnt;

    assign cpuStart = ~tsN & ~ramSpaceN;

    // Column address held for the CAS phase
    always_ff @(posedge CLK40) begin
        if (state == RAM_IDLE && cpuStart) begin
            colQ <= {2'b00, cpu.addr[9:1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // RAM cycle FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            state      <= RAM_IDLE;
            ram        <= '{rasN: 1'b1, casN: 1'b1, weN: 1'b1, clke: 1'b1,
                            bank0: 1'b1, bank1: 1'b1, cma: '0};
            waitCnt    <= '0;
            beatCnt    <= '0;
            ramTa      <= 1'b0;
            burstCycle <= 1'b0;
            dmaCycle   <= 1'b0;
            dbEnN      <= 1'b1;
        end else begin
            ramTa    <= 1'b0;
            // Agnus has the RAM only while the CPU leaves it alone
            dmaCycle <= ~agnusDmaN & (state == RAM_IDLE) & ~cpuStart;
            case (state)
                RAM_IDLE: begin
                    if (cpuStart) begin
                        // Row out with RAS
                        ram.rasN   <= 1'b0;
                        ram.weN    <= cpu.rnW;
                        ram.cma    <= cpu.addr[20:10];
                        ram.bank0  <= cpu.addr[20];
                        ram.bank1  <= ~cpu.addr[20];
                        burstCycle <= (cpu.siz == SIZ_LINE);
                        waitCnt    <= '0;
                        state      <= RAM_RAS_WAIT;
                    end
                end
                RAM_RAS_WAIT: begin
                    if (waitCnt == RAS_WAIT_LAST) begin
                        // Column out with CAS, data buffers on
                        ram.casN <= 1'b0;
                        ram.cma  <= colQ;
                        dbEnN    <= 1'b0;
                        waitCnt  <= '0;
                        state    <= RAM_CAS_WAIT;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                RAM_CAS_WAIT: begin
                    if (waitCnt == CAS_WAIT_LAST) begin
                        ramTa   <= 1'b1;
                        beatCnt <= '0;
                        state   <= RAM_BEAT;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                RAM_BEAT: begin
                    if (burstCycle && beatCnt != BEAT_LAST) begin
                        // Next beat, column wraps within the line
                        ramTa          <= 1'b1;
                        beatCnt        <= beatCnt + 1'b1;
                        ram.cma[1:0]   <= ram.cma[1:0] + 2'd1;
                    end else begin
                        ram.rasN <= 1'b1;
                        ram.casN <= 1'b1;
                        ram.weN  <= 1'b1;
                        dbEnN    <= 1'b1;
                        state    <= RAM_PRE;
                    end
                end
                default: begin
                    // Precharge, spans the last ta
                    burstCycle <= 1'b0;
                    state      <= RAM_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/transferAck.sv
//////////////////////////////////////////////////////////////////////
// 68040 transfer acknowledge and burst inhibit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module transferAck (
    input  wire  CLK40,
    input  wire  rstN,
    input  wire  regTa,
    input  wire  ramTa,
    input  wire  burstCycle,
    output logic ta,
    output logic tbiN
);

    logic anyTa;

    // Register and RAM cycles never overlap, so a plain OR merges them
    assign anyTa = regTa | ramTa;

    // One ta per acknowledge pulse, a cycle later
    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            ta <= 1'b0;
        end else begin
            ta <= anyTa;
        end
    end

    // TBI high accepts the line burst
    // Low on all other cycles forces single transfers
    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            tbiN <= 1'b0;
        end else begin
            tbiN <= burstCycle;
        end
    end

endmodule

`default_nettype wire

// File: rtl/u712Top.sv
//////////////////////////////////////////////////////////////////////
// Chipset glue top with byte enables, register cycle, chip RAM, ta
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u712Top (
    input  wire                    CLK40,
    input  wire                    rstN,
    input  wire u712Pkg::cpuReqT   cpu,
    input  wire                    tsN,
    input  wire                    regSpaceN,
    input  wire                    ramSpaceN,
    input  wire                    c1,
    input  wire                    c3,
    input  wire                    agnusDmaN,
    input  wire                    casLN,
    input  wire                    casUN,
    output wire u712Pkg::laneEnT   cpuLanes,
    output wire u712Pkg::laneEnT   chipLanes,
    output wire u712Pkg::ramCtlT   ram,
    output wire                    asN,
    output wire                    udsN,
    output wire                    ldsN,
    output wire                    regEnN,
    output wire                    dbDir,
    output wire                    vBufEnN,
    output wire                    drdEnN,
    output wire                    drdDir,
    output wire                    dbEnN,
    output wire                    ta,
    output wire                    tbiN
);

    wire dmaCycle;
    wire regTa;
    wire ramTa;
    wire burstCycle;

    //////////////////////////////////////////////////////////////////////
    // Byte lanes
    //////////////////////////////////////////////////////////////////////

    byteEnable uByteEnable (
        .siz       (cpu.siz),
        .addrLow   (cpu.addr[1:0]),
        .dmaCycle  (dmaCycle),
        .casLN     (casLN),
        .casUN     (casUN),
        .cpuLanes  (cpuLanes),
        .chipLanes (chipLanes)
    );

    //////////////////////////////////////////////////////////////////////
    // Register and RAM cycles
    //////////////////////////////////////////////////////////////////////

    regCycle uRegCycle (
        .CLK40     (CLK40),
        .rstN      (rstN),
        .c1        (c1),
        .c3        (c3),
        .tsN       (tsN),
        .regSpaceN (regSpaceN),
        .rnW       (cpu.rnW),
        .siz       (cpu.siz),
        .addrLow   (cpu.addr[1:0]),
        .dmaCycle  (dmaCycle),
        .asN       (asN),
        .udsN      (udsN),
        .ldsN      (ldsN),
        .regEnN    (regEnN),
        .regTa     (regTa),
        .dbDir     (dbDir),
        .vBufEnN   (vBufEnN),
        .drdEnN    (drdEnN),
        .drdDir    (drdDir)
    );

    chipRamCycle uChipRamCycle (
        .CLK40      (CLK40),
        .rstN       (rstN),
        .tsN        (tsN),
        .ramSpaceN  (ramSpaceN),
        .cpu        (cpu),
        .agnusDmaN  (agnusDmaN),
        .ram        (ram),
        .ramTa      (ramTa),
        .burstCycle (burstCycle),
        .dmaCycle   (dmaCycle),
        .dbEnN      (dbEnN)
    );

    // CPU acknowledge
    transferAck uTransferAck (
        .CLK40      (CLK40),
        .rstN       (rstN),
        .regTa      (regTa),
        .ramTa      (ramTa),
        .burstCycle (burstCycle),
        .ta         (ta),
        .tbiN       (tbiN)
    );

endmodule

`default_nettype wire

// File: sim/u712Assert.sv
//////////////////////////////////////////////////////////////////////
// Bus protocol assertions bound into u712Top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u712Assert (
    input wire                  CLK40,
    input wire                  rstN,
    input wire                  tsN,
    input wire                  ta,
    input wire                  tbiN,
    input wire                  vBufEnN,
    input wire u712Pkg::ramCtlT ram
);

    // Outside a line burst ta lasts one cycle
    taSinglePulse: assert property (@(posedge CLK40) disable iff (!rstN)
        ta && !tbiN |=> !ta)
        else $error("ta held past one cycle");

    // CAS before RAS is never issued
    casUnderRas: assert property (@(posedge CLK40) disable iff (!rstN)
        $fell(ram.casN) |-> !ram.rasN)
        else $error("nCas fell with nRas high");

    // Register busy shows as vBufEnN low, RAM busy as nRas low
    noStartWhenBusy: assert property (@(posedge CLK40) disable iff (!rstN)
        !tsN |-> vBufEnN && ram.rasN)
        else $error("tsN during an active cycle");

endmodule

bind u712Top u712Assert uAssert (
    .CLK40(CLK40), .rstN(rstN), .tsN(tsN), .ta(ta), .tbiN(tbiN),
    .vBufEnN(vBufEnN), .ram(ram)
);

`default_nettype wire

// File: sim/tbU712.sv
//////////////////////////////////////////////////////////////////////
// Testbench for u712Top with LCG stimulus and reference functions
// Covers reset, byte lanes, chip RAM, line bursts, register and DMA
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbU712;
    import u712Pkg::*;

    logic    CLK40 = 1'b0;
    logic    rstN;
    cpuReqT  cpu;
    logic    tsN, regSpaceN, ramSpaceN, c1, c3, agnusDmaN, casLN, casUN;
    laneEnT  cpuLanes, chipLanes;
    ramCtlT  ram;
    wire     asN, udsN, ldsN, regEnN, dbDir, vBufEnN, drdEnN, drdDir, dbEnN, ta, tbiN;

    logic [31:0] seed = 32'd86793;
    int          mismatches = 0;
    int          timeouts = 0;
    int          phaseCnt;
    logic [1:0]  laneMode = 2'd0;

    u712Top i_dut (
        .CLK40(CLK40), .rstN(rstN), .cpu(cpu), .tsN(tsN), .regSpaceN(regSpaceN),
        .ramSpaceN(ramSpaceN), .c1(c1), .c3(c3), .agnusDmaN(agnusDmaN),
        .casLN(casLN), .casUN(casUN), .cpuLanes(cpuLanes), .chipLanes(chipLanes),
        .ram(ram), .asN(asN), .udsN(udsN), .ldsN(ldsN), .regEnN(regEnN),
        .dbDir(dbDir), .vBufEnN(vBufEnN), .drdEnN(drdEnN), .drdDir(drdDir),
        .dbEnN(dbEnN), .ta(ta), .tbiN(tbiN)
    );

    // 4 ns clock
    always #2 CLK40 = ~CLK40;

    ////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] nextRand();
        seed = lcgNext(seed);
        return {16'd0, seed[31:16]};
    endfunction

    // Active low lanes from size and A1:A0
    function automatic laneEnT refLanes(input logic [1:0] siz, input logic [1:0] a);
        laneEnT l;
        l = '1;
        if (siz == SIZ_LONG || siz == SIZ_LINE) l = '0;
        else if (siz == SIZ_WORD) l = a[1] ? 4'b1100 : 4'b0011;
        else l = ~(4'b1000 >> a);
        return l;
    endfunction

    // 68000 view, {udsN, ldsN}
    function automatic logic [1:0] refStrobes(input logic [1:0] siz, input logic [1:0] a);
        if (siz != SIZ_BYTE) return 2'b00;
        return a[0] ? 2'b10 : 2'b01;
    endfunction

    function automatic logic [10:0] refRow(input logic [20:0] addr);
        return addr[20:10];
    endfunction

    function automatic logic [10:0] refCol(input logic [20:0] addr);
        return {2'b00, addr[9:1]};
    endfunction

    function automatic int refBeats(input logic [1:0] siz);
        return (siz == SIZ_LINE) ? BURST_BEATS : 1;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            mismatches++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Phase clocks and lane checker
    ////////////////////////////////////////////////////////////////////

    // Quadrants of 3 CLK40 cycles, c3 trails c1 by one quadrant
    always @(negedge CLK40) begin
        phaseCnt = (phaseCnt + 1) % 12;
        c1       = phaseCnt < 6;
        c3       = phaseCnt >= 3 && phaseCnt < 9;
    end

    always @(posedge CLK40) begin
        if (laneMode == 2'd1) begin
            checkValue("cpuLanes", 32'(cpuLanes), 32'(refLanes(cpu.siz, cpu.addr[1:0])));
            checkValue("chipLanes", 32'(chipLanes), 32'(refLanes(cpu.siz, cpu.addr[1:0])));
        end else if (laneMode == 2'd2) begin
            checkValue("cpuLanes", 32'(cpuLanes), 32'hf);
            checkValue("chipLanes", 32'(chipLanes), 32'({casUN, casUN, casLN, casLN}));
            // Agnus owns the RAM, data buffers stay off
            checkValue("drdEnN", 32'(drdEnN), 1);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Bus operations
    ////////////////////////////////////////////////////////////////////

    task automatic ramOp(input cpuReqT req);
        int          cnt;
        int          beats;
        int          quiet;
        logic [10:0] prevCma;
        @(negedge CLK40);
        cpu = req;
        tsN = 1'b0;
        ramSpaceN = 1'b0;
        @(negedge CLK40);
        tsN = 1'b1;
        checkValue("rasN", 32'(ram.rasN), 0);
        checkValue("cma row", 32'(ram.cma), 32'(refRow(req.addr)));
        checkValue("bank0", 32'(ram.bank0), 32'(req.addr[20]));
        checkValue("bank1", 32'(ram.bank1), 32'(!req.addr[20]));
        checkValue("weN", 32'(ram.weN), 32'(req.rnW));
        checkValue("vBufEnN", 32'(vBufEnN), 1);
        cnt = 0;
        while (ram.casN && cnt < 10) begin
            @(negedge CLK40);
            cnt++;
        end
        if (ram.casN) reportTimeout("nCas fall");
        checkValue("ras to cas cycles", cnt, RAS_TO_CAS);
        checkValue("cma column", 32'(ram.cma), 32'(refCol(req.addr)));
        // Data path opens with CAS
        checkValue("dbEnN", 32'(dbEnN), 0);
        checkValue("drdEnN", 32'(drdEnN), 0);
        checkValue("drdDir", 32'(drdDir), 32'(req.rnW));
        cnt = 0;
        beats = 0;
        quiet = 0;
        prevCma = ram.cma;
        while (quiet < 4 && cnt < 30) begin
            @(negedge CLK40);
            cnt++;
            if (ta) begin
                if (beats == 0) checkValue("cas to ta cycles", cnt, CAS_TO_TA + 1);
                checkValue("tbiN", 32'(tbiN), 32'(req.siz == SIZ_LINE));
                checkValue("cma beat", 32'(prevCma),
                           32'({refCol(req.addr) >> 2, req.addr[2:1] + 2'(beats)}));
                beats++;
                quiet = 0;
            end else if (beats > 0) begin
                quiet++;
            end
            prevCma = ram.cma;
        end
        if (quiet < 4) reportTimeout("chip RAM ta");
        checkValue("ta beats", beats, refBeats(req.siz));
        checkValue("rasN idle", 32'(ram.rasN), 1);
        checkValue("casN idle", 32'(ram.casN), 1);
        checkValue("dbEnN idle", 32'(dbEnN), 1);
        ramSpaceN = 1'b1;
    endtask

    task automatic regOp(input cpuReqT req);
        int         cnt;
        int         taCount;
        logic [1:0] lastStrobes;
        @(negedge CLK40);
        cpu = req;
        tsN = 1'b0;
        regSpaceN = 1'b0;
        @(negedge CLK40);
        tsN = 1'b1;
        cnt = 0;
        while (asN && cnt < 60) begin
            @(negedge CLK40);
            cnt++;
        end
        if (asN) reportTimeout("nAs fall");
        cnt = 0;
        lastStrobes = 2'b11;
        while (!ta && cnt < 80) begin
            if (!asN) begin
                checkValue("regEnN", 32'(regEnN), 0);
                checkValue("vBufEnN", 32'(vBufEnN), 0);
                checkValue("dbDir", 32'(dbDir), 32'(req.rnW));
                checkValue("drdDir", 32'(drdDir), 32'(req.rnW));
                lastStrobes = {udsN, ldsN};
            end
            @(negedge CLK40);
            cnt++;
        end
        if (!ta) reportTimeout("register cycle ta");
        checkValue("udsN ldsN", 32'(lastStrobes), 32'(refStrobes(req.siz, req.addr[1:0])));
        taCount = int'(ta);
        // Look for stray acknowledges
        repeat (6) begin
            @(negedge CLK40);
            taCount += int'(ta);
        end
        checkValue("register ta count", taCount, 1);
        checkValue("asN idle", 32'(asN), 1);
        regSpaceN = 1'b1;
    endtask

    task automatic dmaTest();
        agnusDmaN = 1'b0;
        laneMode = 2'd0;
        repeat (2) @(negedge CLK40);
        laneMode = 2'd2;
        repeat (8) begin
            @(negedge CLK40);
            casLN = 1'(nextRand());
            casUN = 1'(nextRand());
        end
        @(negedge CLK40);
        agnusDmaN = 1'b1;
        laneMode = 2'd0;
        repeat (2) @(negedge CLK40);
        laneMode = 2'd1;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        cpuReqT req;
        int     kind;
        rstN = 1'b0;
        cpu = '0;
        tsN = 1'b1;
        regSpaceN = 1'b1;
        ramSpaceN = 1'b1;
        agnusDmaN = 1'b1;
        casLN = 1'b1;
        casUN = 1'b1;
        phaseCnt = nextRand() % 12;
        c1 = phaseCnt < 6;
        c3 = phaseCnt >= 3 && phaseCnt < 9;
        repeat (10) @(negedge CLK40);
        rstN = 1'b1;
        @(negedge CLK40);
        checkValue("reset strobes",
                   32'({asN, udsN, ldsN, ram.rasN, ram.casN, ram.weN}), 32'h3f);
        checkValue("reset ta", 32'(ta), 0);
        checkValue("reset clke", 32'(ram.clke), 1);
        laneMode = 2'd1;
        // Idle lane sweep
        repeat (16) begin
            @(negedge CLK40);
            cpu.siz = 2'(nextRand());
            cpu.addr[1:0] = 2'(nextRand());
        end
        repeat (24) begin
            req.addr = 21'({nextRand(), nextRand()});
            req.siz = 2'(nextRand());
            req.rnW = 1'(nextRand());
            req.tt = 2'b00;
            kind = nextRand() % 3;
            if (kind == 0) regOp(req);
            else if (kind == 1) ramOp(req);
            else begin
                req.siz = SIZ_LINE;
                ramOp(req);
            end
            repeat (4) @(negedge CLK40);
        end
        dmaTest();
        repeat (4) @(negedge CLK40);
        $display("Errors mismatches=%0d timeouts=%0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/u712Pkg.sv
rtl/byteEnable.sv
rtl/regCycle.sv
rtl/chipRamCycle.sv
rtl/transferAck.sv
rtl/u712Top.sv
sim/u712Assert.sv
sim/tbU712.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile: obj_dir/VtbU712

obj_dir/VtbU712: tb.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tbU712 -f tb.f

run: compile
	./obj_dir/VtbU712 | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
